// ==== Makefile ====
# Verilator build and run for the L2 cache testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module l2_cache_tb -f vlog.f -o Vl2_cache_tb

run: compile
	-./obj_dir/Vl2_cache_tb +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/l2_cache_chk.sv ====
/*
 * L2 cache port protocol checks
 * Bound to the cache top level. Covers the quiet period after reset,
 * exclusive memory commands, stable memory requests and single-cycle
 * client responses.
 */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_chk (
    input wire                         clk,
    input wire                         rst_n_i,
    input wire                         mem_read_i,
    input wire                         mem_write_i,
    input wire                         mem_resp_i,
    input wire                         pmem_read_i,
    input wire                         pmem_write_i,
    input wire                         pmem_resp_i,
    input wire cache_types_pkg::addr_t pmem_address_i,
    input wire cache_types_pkg::line_t pmem_wdata_i
);

    int   fail_count = 0; // Failed assertion count
    logic req_seen;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_seen <= 1'b0;
        end else if (mem_read_i || mem_write_i) begin
            req_seen <= 1'b1;
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        !req_seen && !mem_read_i && !mem_write_i |-> !mem_resp_i && !pmem_read_i && !pmem_write_i)
        else begin
            $error("Cache port active after reset before any client request");
            fail_count = fail_count + 1;
        end

    pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(pmem_read_i && pmem_write_i))
        else begin
            $error("Memory read and write asserted in the same cycle");
            fail_count = fail_count + 1;
        end

    pmem_read_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        pmem_read_i && !pmem_resp_i |=> pmem_read_i && $stable(pmem_address_i))
        else begin
            $error("Memory read dropped or its address changed before the response");
            fail_count = fail_count + 1;
        end

    pmem_write_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        pmem_write_i && !pmem_resp_i |=>
            pmem_write_i && $stable(pmem_address_i) && $stable(pmem_wdata_i))
        else begin
            $error("Memory write dropped or its address or data changed before the response");
            fail_count = fail_count + 1;
        end

    resp_only_on_request: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_resp_i |-> mem_read_i || mem_write_i)
        else begin
            $error("Client response given with no request held");
            fail_count = fail_count + 1;
        end

    resp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_resp_i |=> !mem_resp_i)
        else begin
            $error("Client response held longer than one cycle");
            fail_count = fail_count + 1;
        end

endmodule

`default_nettype wire

// ==== bench/l2_cache_tb.sv ====
/*
 * L2 cache testbench
 * Random reads and writes over a small pool of conflicting lines, a
 * memory model with random latency, and a shadow model that checks read
 * data, write-back data and hit latency.
 */
`timescale 1ns/10ps
`include "l2_cache_config.svh"
`default_nettype none

module l2_cache_tb;

    localparam int NUM_OPS     = 400;
    localparam int CYCLE_LIMIT = NUM_OPS * 40;

    logic                   clk;
    logic                   rst_n_i;
    cache_types_pkg::addr_t mem_address_i;
    cache_types_pkg::line_t mem_wdata_i;
    logic                   mem_read_i;
    logic                   mem_write_i;
    cache_types_pkg::line_t mem_rdata_o;
    logic                   mem_resp_o;
    cache_types_pkg::addr_t pmem_address_o;
    cache_types_pkg::line_t pmem_wdata_o;
    cache_types_pkg::line_t pmem_rdata_i;
    logic                   pmem_read_o;
    logic                   pmem_write_o;
    logic                   pmem_resp_i;

    cache_types_pkg::line_t mem_lines [cache_types_pkg::addr_t]; // Lines written back
    cache_types_pkg::line_t shadow    [cache_types_pkg::addr_t]; // Latest client data
    logic [15:0]            lfsr;
    int                     errors;
    int                     cycle_count;

    l2_cache l2_cache_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_address_i  (mem_address_i),
        .mem_wdata_i    (mem_wdata_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .mem_rdata_o    (mem_rdata_o),
        .mem_resp_o     (mem_resp_o),
        .pmem_address_o (pmem_address_o),
        .pmem_wdata_o   (pmem_wdata_o),
        .pmem_rdata_i   (pmem_rdata_i),
        .pmem_read_o    (pmem_read_o),
        .pmem_write_o   (pmem_write_o),
        .pmem_resp_i    (pmem_resp_i)
    );

    bind l2_cache l2_cache_chk chk_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .mem_resp_i     (mem_resp_o),
        .pmem_read_i    (pmem_read_o),
        .pmem_write_i   (pmem_write_o),
        .pmem_resp_i    (pmem_resp_i),
        .pmem_address_i (pmem_address_o),
        .pmem_wdata_i   (pmem_wdata_o)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic cache_types_pkg::line_t random_line();
        cache_types_pkg::line_t d;
        for (int k = 0; k < cache_types_pkg::LINE_BITS / 32; k++) begin
            d[k*32 +: 32] = random_bits(32);
        end
        return d;
    endfunction

    function automatic cache_types_pkg::addr_t make_addr(input int k,
                                                         input cache_types_pkg::index_t set,
                                                         input logic [`L2_OFFSET_BITS-1:0] offset);
        cache_types_pkg::tag_t tag;
        tag = cache_types_pkg::tag_t'((k + 1) * 24'h01_1357); // Six distinct tags
        return {tag, set, offset};
    endfunction

    function automatic cache_types_pkg::addr_t line_of(input cache_types_pkg::addr_t a);
        return {a[`L2_ADDR_BITS-1:`L2_OFFSET_BITS], {`L2_OFFSET_BITS{1'b0}}};
    endfunction

    // Content of a line that nobody has written yet
    function automatic cache_types_pkg::line_t address_pattern(input cache_types_pkg::addr_t a);
        cache_types_pkg::line_t p;
        for (int k = 0; k < cache_types_pkg::LINE_BITS / 32; k++) begin
            p[k*32 +: 32] = a ^ (32'h9E37_79B9 * (k + 1));
        end
        return p;
    endfunction

    function automatic cache_types_pkg::line_t expected_line(input cache_types_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : address_pattern(a);
    endfunction

    task automatic client_access(input logic is_write, input cache_types_pkg::addr_t addr,
                                 input cache_types_pkg::line_t data, output int cycles);
        cache_types_pkg::addr_t line_addr;
        line_addr     = line_of(addr);
        mem_address_i = addr;
        mem_wdata_i   = data;
        mem_read_i    = !is_write;
        mem_write_i   = is_write;
        cycles        = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!mem_resp_o);
        if (is_write) begin
            shadow[line_addr] = data;
        end else begin
            assert (mem_rdata_o == expected_line(line_addr)) else begin
                $error("Mismatch at %0t: mem_rdata_o expected %h got %h",
                       $time, expected_line(line_addr), mem_rdata_o);
                errors++;
            end
        end
        @(negedge clk);
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
    endtask

    always #20 clk = ~clk;

    always @(posedge clk) begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the cache stopped answering", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    always begin : memory_model
        int latency;
        @(posedge clk);
        if (pmem_read_o || pmem_write_o) begin
            latency = 1 + int'(random_bits(3));
            repeat (latency) @(negedge clk);
            if (pmem_write_o) begin
                assert (pmem_wdata_o == expected_line(pmem_address_o)) else begin
                    $error("Mismatch at %0t: pmem_wdata_o expected %h got %h",
                           $time, expected_line(pmem_address_o), pmem_wdata_o);
                    errors++;
                end
                mem_lines[pmem_address_o] = pmem_wdata_o;
            end else begin
                pmem_rdata_i = mem_lines.exists(pmem_address_o) ? mem_lines[pmem_address_o]
                                                                : address_pattern(pmem_address_o);
            end
            pmem_resp_i = 1'b1;
            @(negedge clk);
            pmem_resp_i = 1'b0;
        end
    end

    initial begin : stimulus
        int                      cycles;
        int                      tag_sel;
        int                      protocol_errors;
        logic                    is_write;
        cache_types_pkg::index_t set;
        logic [`L2_OFFSET_BITS-1:0] offset;
        cache_types_pkg::addr_t  addr;
        cache_types_pkg::line_t  data;
        clk           = 1'b0;
        rst_n_i       = 1'b1;
        mem_address_i = '0;
        mem_wdata_i   = '0;
        mem_read_i    = 1'b0;
        mem_write_i   = 1'b0;
        pmem_rdata_i  = '0;
        pmem_resp_i   = 1'b0;
        lfsr          = 16'd52581;
        errors        = 0;
        cycle_count   = 0;
        #1 rst_n_i = 1'b0;
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;
        repeat (5) @(negedge clk); // Quiet ports with no request after reset

        // Dirty line pushed out by five conflicting lines, then read back
        client_access(1'b1, make_addr(0, 3'd2, '0), random_line(), cycles);
        for (int k = 1; k < 6; k++) begin
            client_access(1'b0, make_addr(k, 3'd2, '0), '0, cycles);
        end
        client_access(1'b0, make_addr(0, 3'd2, '0), '0, cycles);

        for (int n = 0; n < NUM_OPS; n++) begin
            is_write = random_bits(1) != 0;
            tag_sel  = int'(random_bits(3)) % 6;
            set      = (random_bits(1) != 0) ? 3'd2 : 3'd5;
            offset   = random_bits(`L2_OFFSET_BITS);
            addr     = make_addr(tag_sel, set, offset);
            data     = is_write ? random_line() : '0;
            client_access(is_write, addr, data, cycles);
            if (random_bits(1) != 0) begin
                client_access(1'b0, addr, '0, cycles); // Same line right after the response
                assert (cycles == 2) else begin
                    $error("Mismatch at %0t: mem_resp_o cycle expected 2 got %0d", $time, cycles);
                    errors++;
                end
            end
            repeat (random_bits(2)) @(negedge clk); // Idle gap lets the buffer drain
        end
        repeat (40) @(negedge clk);

        protocol_errors = l2_cache_inst.chk_inst.fail_count;
        $display("Checks done: %0d data errors, %0d protocol errors", errors, protocol_errors);
        if (errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/cache_ctrl_pkg.sv ====
/*
 * Cache controller types
 * Controller state encoding and the data-array write source select.
 */
`include "l2_cache_config.svh"
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        EVICT,
        FETCH,
        DRAIN
    } ctrl_state_t;

    typedef enum logic {
        FROM_CLIENT,
        FROM_MEMORY
    } data_sel_t;

endpackage

`default_nettype wire

// ==== design/cache_types_pkg.sv ====
/*
 * Cache datapath types
 * Vector typedefs for addresses, tags, set indexes, lines, ways and
 * the per-set pseudo-LRU tree, derived from the build configuration.
 */
`include "l2_cache_config.svh"
`default_nettype none

package cache_types_pkg;

    localparam int TAG_BITS  = `L2_ADDR_BITS - `L2_OFFSET_BITS - `L2_INDEX_BITS;
    localparam int LINE_BITS = 8 << `L2_OFFSET_BITS;
    localparam int NUM_WAYS  = 4;
    localparam int NUM_SETS  = 1 << `L2_INDEX_BITS;

    typedef logic [`L2_ADDR_BITS-1:0]  addr_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [`L2_INDEX_BITS-1:0] index_t;
    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [1:0]                way_t;
    typedef logic [2:0]                plru_t; // Root, left pair, right pair

endpackage

`default_nettype wire

// ==== design/ewb.sv ====
/*
 * Eviction write buffer
 * Circular FIFO of dirty victim lines waiting for write-back, with an
 * associative lookup by line address where the newest match wins.
 */
`timescale 1ns/10ps
`include "l2_cache_config.svh"
`default_nettype none

module ewb (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         push_i,
    input  wire                         pop_i,
    input  wire cache_types_pkg::addr_t push_addr_i,
    input  wire cache_types_pkg::line_t push_data_i,
    input  wire cache_types_pkg::addr_t lookup_addr_i,
    output logic                        empty_o,
    output logic                        full_o,
    output logic                        lookup_hit_o,
    output cache_types_pkg::line_t      lookup_data_o,
    output cache_types_pkg::addr_t      head_addr_o,
    output cache_types_pkg::line_t      head_data_o
);

    localparam int DEPTH    = `L2_EWB_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    cache_types_pkg::addr_t entry_addr [DEPTH];
    cache_types_pkg::line_t entry_data [DEPTH];
    logic [PTR_BITS-1:0]    head_ptr;
    logic [PTR_BITS-1:0]    tail_ptr;
    logic [PTR_BITS:0]      count;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o     = (count == 0);
    assign full_o      = (count == DEPTH);
    assign head_addr_o = entry_addr[head_ptr];
    assign head_data_o = entry_data[head_ptr];

    // Walk from oldest to newest so a later match overrides
    always_comb begin
        int slot;
        lookup_hit_o  = 1'b0;
        lookup_data_o = entry_data[head_ptr];
        for (int k = 0; k < DEPTH; k++) begin
            slot = (int'(head_ptr) + k) % DEPTH;
            if ((k < int'(count)) &&
                (entry_addr[slot][`L2_ADDR_BITS-1:`L2_OFFSET_BITS] ==
                 lookup_addr_i[`L2_ADDR_BITS-1:`L2_OFFSET_BITS])) begin
                lookup_hit_o  = 1'b1;
                lookup_data_o = entry_data[slot];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push_i) begin
                tail_ptr <= ptr_inc(tail_ptr);
            end
            if (pop_i) begin
                head_ptr <= ptr_inc(head_ptr);
            end
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            entry_addr[tail_ptr] <= push_addr_i;
            entry_data[tail_ptr] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/l2_cache.sv ====
/*
 * L2 cache top level
 * 4-way set-associative write-back cache with 256-bit lines between a
 * line-wide client port and physical memory. Dirty victims go through
 * an eviction write buffer that can also answer read misses.
 */
`timescale 1ns/10ps
`include "l2_cache_config.svh"
`default_nettype none

module l2_cache (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire cache_types_pkg::addr_t mem_address_i,
    input  wire cache_types_pkg::line_t mem_wdata_i,
    input  wire                         mem_read_i,
    input  wire                         mem_write_i,
    output cache_types_pkg::line_t      mem_rdata_o,
    output logic                        mem_resp_o,
    output cache_types_pkg::addr_t      pmem_address_o,
    output cache_types_pkg::line_t      pmem_wdata_o,
    input  wire cache_types_pkg::line_t pmem_rdata_i,
    output logic                        pmem_read_o,
    output logic                        pmem_write_o,
    input  wire                         pmem_resp_i
);

    logic                      hit;
    cache_types_pkg::way_t     hit_way;
    cache_types_pkg::way_t     victim_way;
    logic                      victim_valid;
    logic                      victim_dirty;
    cache_types_pkg::addr_t    victim_addr;
    cache_types_pkg::line_t    dp_rdata;
    cache_types_pkg::line_t    victim_data;

    logic                      tag_load;
    logic                      valid_load;
    logic                      dirty_load;
    logic                      dirty_value;
    logic                      data_load;
    cache_ctrl_pkg::data_sel_t data_sel;
    logic                      plru_load;
    cache_types_pkg::way_t     way_sel;

    logic                      ewb_hit;
    logic                      ewb_empty;
    logic                      ewb_full;
    logic                      ewb_serve;
    logic                      ewb_push;
    logic                      ewb_pop;
    logic                      drain_sel;
    cache_types_pkg::line_t    ewb_data;
    cache_types_pkg::addr_t    head_addr;
    cache_types_pkg::addr_t    fetch_addr;

    assign fetch_addr = {mem_address_i[`L2_ADDR_BITS-1:`L2_OFFSET_BITS],
                         {`L2_OFFSET_BITS{1'b0}}};

    assign mem_rdata_o    = ewb_serve ? ewb_data : dp_rdata;
    assign pmem_address_o = drain_sel ? head_addr : fetch_addr;

    l2_cache_datapath datapath (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .address_i      (mem_address_i),
        .client_wdata_i (mem_wdata_i),
        .fill_data_i    (pmem_rdata_i),
        .tag_load_i     (tag_load),
        .valid_load_i   (valid_load),
        .dirty_load_i   (dirty_load),
        .dirty_value_i  (dirty_value),
        .data_load_i    (data_load),
        .data_sel_i     (data_sel),
        .plru_load_i    (plru_load),
        .way_sel_i      (way_sel),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_valid_o (victim_valid),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr),
        .rdata_o        (dp_rdata),
        .victim_data_o  (victim_data)
    );

    l2_cache_control control (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_valid_i (victim_valid),
        .victim_dirty_i (victim_dirty),
        .ewb_hit_i      (ewb_hit),
        .ewb_empty_i    (ewb_empty),
        .ewb_full_i     (ewb_full),
        .pmem_resp_i    (pmem_resp_i),
        .mem_resp_o     (mem_resp_o),
        .ewb_serve_o    (ewb_serve),
        .pmem_read_o    (pmem_read_o),
        .pmem_write_o   (pmem_write_o),
        .drain_sel_o    (drain_sel),
        .ewb_push_o     (ewb_push),
        .ewb_pop_o      (ewb_pop),
        .tag_load_o     (tag_load),
        .valid_load_o   (valid_load),
        .dirty_load_o   (dirty_load),
        .dirty_value_o  (dirty_value),
        .data_load_o    (data_load),
        .data_sel_o     (data_sel),
        .plru_load_o    (plru_load),
        .way_sel_o      (way_sel)
    );

    ewb ewb_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .push_i        (ewb_push),
        .pop_i         (ewb_pop),
        .push_addr_i   (victim_addr),
        .push_data_i   (victim_data),
        .lookup_addr_i (mem_address_i),
        .empty_o       (ewb_empty),
        .full_o        (ewb_full),
        .lookup_hit_o  (ewb_hit),
        .lookup_data_o (ewb_data),
        .head_addr_o   (head_addr),
        .head_data_o   (pmem_wdata_o)
    );

endmodule

`default_nettype wire

// ==== design/l2_cache_config.svh ====
/*
 * L2 cache build configuration
 * Address width, line offset, set index and eviction buffer depth.
 * Way count is fixed at 4 by the 3-bit pseudo-LRU tree.
 */
`default_nettype none

`ifndef L2_CACHE_CONFIG_SVH
`define L2_CACHE_CONFIG_SVH

`define L2_ADDR_BITS   32 // Byte address width
`define L2_OFFSET_BITS 5  // 32-byte lines
`define L2_INDEX_BITS  3  // 8 sets
`define L2_EWB_DEPTH   2  // Eviction write buffer entries

`endif

`default_nettype wire

// ==== design/l2_cache_control.sv ====
/*
 * L2 cache controller
 * Sequences hits, buffer-served reads, evictions into the write buffer,
 * line refills and write buffer drains to physical memory.
 */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_control (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         mem_read_i,
    input  wire                         mem_write_i,
    input  wire                         hit_i,
    input  wire cache_types_pkg::way_t  hit_way_i,
    input  wire cache_types_pkg::way_t  victim_way_i,
    input  wire                         victim_valid_i,
    input  wire                         victim_dirty_i,
    input  wire                         ewb_hit_i,
    input  wire                         ewb_empty_i,
    input  wire                         ewb_full_i,
    input  wire                         pmem_resp_i,
    output logic                        mem_resp_o,
    output logic                        ewb_serve_o,
    output logic                        pmem_read_o,
    output logic                        pmem_write_o,
    output logic                        drain_sel_o,
    output logic                        ewb_push_o,
    output logic                        ewb_pop_o,
    output logic                        tag_load_o,
    output logic                        valid_load_o,
    output logic                        dirty_load_o,
    output logic                        dirty_value_o,
    output logic                        data_load_o,
    output cache_ctrl_pkg::data_sel_t   data_sel_o,
    output logic                        plru_load_o,
    output cache_types_pkg::way_t       way_sel_o
);

    cache_ctrl_pkg::ctrl_state_t state, state_next;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= cache_ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next    = state;
        mem_resp_o    = 1'b0;
        ewb_serve_o   = 1'b0;
        pmem_read_o   = 1'b0;
        pmem_write_o  = 1'b0;
        drain_sel_o   = 1'b0;
        ewb_push_o    = 1'b0;
        ewb_pop_o     = 1'b0;
        tag_load_o    = 1'b0;
        valid_load_o  = 1'b0;
        dirty_load_o  = 1'b0;
        dirty_value_o = 1'b0;
        data_load_o   = 1'b0;
        data_sel_o    = cache_ctrl_pkg::FROM_CLIENT;
        plru_load_o   = 1'b0;
        way_sel_o     = victim_way_i;

        case (state)
            cache_ctrl_pkg::IDLE: begin
                if (mem_read_i || mem_write_i) begin
                    state_next = cache_ctrl_pkg::CHECK;
                end else if (!ewb_empty_i) begin
                    state_next = cache_ctrl_pkg::DRAIN; // Background write-back
                end
            end
            cache_ctrl_pkg::CHECK: begin
                way_sel_o = hit_way_i;
                if (!(mem_read_i || mem_write_i)) begin
                    state_next = cache_ctrl_pkg::IDLE;
                end else if (hit_i) begin
                    mem_resp_o  = 1'b1;
                    plru_load_o = 1'b1;
                    if (mem_write_i) begin
                        data_load_o   = 1'b1;
                        dirty_load_o  = 1'b1;
                        dirty_value_o = 1'b1;
                    end
                    state_next = cache_ctrl_pkg::IDLE;
                end else if (ewb_hit_i && mem_read_i) begin
                    mem_resp_o  = 1'b1; // Served from the write buffer, no allocate
                    ewb_serve_o = 1'b1;
                    state_next  = cache_ctrl_pkg::IDLE;
                end else if (ewb_hit_i) begin
                    state_next = cache_ctrl_pkg::DRAIN; // Stale copy must reach memory first
                end else if (victim_valid_i && victim_dirty_i) begin
                    state_next = cache_ctrl_pkg::EVICT;
                end else begin
                    state_next = cache_ctrl_pkg::FETCH;
                end
            end
            cache_ctrl_pkg::EVICT: begin
                if (ewb_full_i) begin
                    state_next = cache_ctrl_pkg::DRAIN;
                end else begin
                    ewb_push_o = 1'b1;
                    state_next = cache_ctrl_pkg::FETCH;
                end
            end
            cache_ctrl_pkg::FETCH: begin
                pmem_read_o = 1'b1;
                if (pmem_resp_i) begin
                    data_load_o  = 1'b1;
                    data_sel_o   = cache_ctrl_pkg::FROM_MEMORY;
                    tag_load_o   = 1'b1;
                    valid_load_o = 1'b1;
                    dirty_load_o = 1'b1; // Fresh line is clean
                    state_next   = cache_ctrl_pkg::CHECK;
                end
            end
            cache_ctrl_pkg::DRAIN: begin
                pmem_write_o = 1'b1;
                drain_sel_o  = 1'b1;
                if (pmem_resp_i) begin
                    ewb_pop_o  = 1'b1;
                    state_next = cache_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_next = cache_ctrl_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/l2_cache_datapath.sv ====
/*
 * L2 cache datapath
 * Four ways of tag, valid, dirty and line storage with one pseudo-LRU
 * tree per set. Lookup is combinational. Victim is the lowest invalid
 * way, otherwise the way the tree points at.
 */
`timescale 1ns/10ps
`include "l2_cache_config.svh"
`default_nettype none

module l2_cache_datapath (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire cache_types_pkg::addr_t address_i,
    input  wire cache_types_pkg::line_t client_wdata_i,
    input  wire cache_types_pkg::line_t fill_data_i,
    input  wire                         tag_load_i,
    input  wire                         valid_load_i,
    input  wire                         dirty_load_i,
    input  wire                         dirty_value_i,
    input  wire                         data_load_i,
    input  wire cache_ctrl_pkg::data_sel_t data_sel_i,
    input  wire                         plru_load_i,
    input  wire cache_types_pkg::way_t  way_sel_i,
    output logic                        hit_o,
    output cache_types_pkg::way_t       hit_way_o,
    output cache_types_pkg::way_t       victim_way_o,
    output logic                        victim_valid_o,
    output logic                        victim_dirty_o,
    output cache_types_pkg::addr_t      victim_addr_o,
    output cache_types_pkg::line_t      rdata_o,
    output cache_types_pkg::line_t      victim_data_o
);

    localparam int WAYS = cache_types_pkg::NUM_WAYS;
    localparam int SETS = cache_types_pkg::NUM_SETS;

    cache_types_pkg::tag_t   tag_arr   [WAYS][SETS];
    cache_types_pkg::line_t  data_arr  [WAYS][SETS];
    logic [WAYS-1:0]         valid_arr [SETS];
    logic [WAYS-1:0]         dirty_arr [SETS];
    cache_types_pkg::plru_t  plru_arr  [SETS];

    cache_types_pkg::index_t idx;
    cache_types_pkg::tag_t   tag;
    logic [WAYS-1:0]         way_match;
    cache_types_pkg::way_t   plru_way;
    cache_types_pkg::plru_t  plru_next;

    assign idx = address_i[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    assign tag = address_i[`L2_ADDR_BITS-1 -: cache_types_pkg::TAG_BITS];

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_match[w] = valid_arr[idx][w] && (tag_arr[w][idx] == tag);
            if (way_match[w]) begin
                hit_way_o = cache_types_pkg::way_t'(w);
            end
        end
    end

    assign hit_o = |way_match;

    // Tree bits point toward the least recently used side
    assign plru_way = plru_arr[idx][0] ? {1'b1, plru_arr[idx][2]} : {1'b0, plru_arr[idx][1]};

    always_comb begin
        victim_way_o = plru_way;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_arr[idx][w]) begin
                victim_way_o = cache_types_pkg::way_t'(w); // Lowest invalid way
            end
        end
    end

    assign victim_valid_o = valid_arr[idx][victim_way_o];
    assign victim_dirty_o = dirty_arr[idx][victim_way_o];
    assign victim_addr_o  = {tag_arr[victim_way_o][idx], idx, {`L2_OFFSET_BITS{1'b0}}};
    assign victim_data_o  = data_arr[victim_way_o][idx];
    assign rdata_o        = data_arr[hit_way_o][idx];

    always_comb begin
        plru_next    = plru_arr[idx];
        plru_next[0] = ~way_sel_i[1]; // Point away from the accessed pair
        if (way_sel_i[1]) begin
            plru_next[2] = ~way_sel_i[0];
        end else begin
            plru_next[1] = ~way_sel_i[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
                plru_arr[s]  <= '0;
            end
        end else begin
            if (valid_load_i) begin
                valid_arr[idx][way_sel_i] <= 1'b1;
            end
            if (dirty_load_i) begin
                dirty_arr[idx][way_sel_i] <= dirty_value_i;
            end
            if (plru_load_i) begin
                plru_arr[idx] <= plru_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_load_i) begin
            tag_arr[way_sel_i][idx] <= tag;
        end
        if (data_load_i) begin
            data_arr[way_sel_i][idx] <= (data_sel_i == cache_ctrl_pkg::FROM_MEMORY) ?
                                        fill_data_i : client_wdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/cache_types_pkg.sv
design/cache_ctrl_pkg.sv
design/l2_cache_datapath.sv
design/l2_cache_control.sv
design/ewb.sv
design/l2_cache.sv
bench/l2_cache_chk.sv
bench/l2_cache_tb.sv
